//--- bench/coreCases.txt
// Case: word count, program words, illegal flag, event count, then events as kind reg/addr data
// Kind 1 is a register write, kind 2 a memory write; a word count of zero ends the file
// Case 1: R-format ALU, shifts, compares and BTR
0011
C181 C213 C303 D950 D951 D952 D953 D174 D175 D176 D177 E258 E958 F238 F938 C91C 0000
0 0010
1 0001 FF81  1 0002 0013  1 0003 0003  1 0004 FF94
1 0004 0092  1 0004 FF92  1 0004 FF80  1 0005 FC0F
1 0005 FC08  1 0005 3FF0  1 0005 1FF0  1 0006 0001
1 0006 0001  1 0006 0000  1 0006 0001  1 0007 81FF
// Case 2: I-format sign and zero extension, LBI then SLBI
000B
403D 505D 4965 599F A1A4 AAA2 B2C1 B9C8 C7BE 97EF 0000
0 000A
1 0001 FFFD  1 0002 001D  1 0003 0008  1 0004 FFE0  1 0005 FFDF
1 0005 0074  1 0006 800E  1 0006 00FF  1 0007 FFBE  1 0007 BEEF
// Case 3: ST, LD and STU
000A
C120 C212 9234 8144 8964 4361 997E 8980 89A6 0000
0 000A
1 0001 0020  1 0002 0012  1 0002 1234  2 0024 1234  1 0003 1234
1 0003 1235  1 0001 001E  2 001E 1235  1 0004 1235  1 0005 1234
// Case 4: each branch taken and not taken
0013
C180 C205 6002 C701 6202 C602 6A02 C703 6802 C604
7102 C705 7202 C606 7802 C707 7902 C608 0000
0 0006
1 0001 FF80  1 0002 0005  1 0006 0002  1 0006 0004  1 0006 0006  1 0006 0008
// Case 5: J, JAL, JR and JALR
000D
2002 C611 3002 C622 C110 2900 C633 C644 C216 3A00 C655 47A1 0000
0 0005
1 0007 0006  1 0001 0010  1 0002 0016  1 0007 0014  1 0005 0015
// Case 6: NOP, SIIC and RTI change nothing, nothing runs past HALT
0007
C142 0800 1000 1800 4140 0000 C377
0 0002
1 0001 0042  1 0002 0042
// Case 7: reserved func on SEQ halts with illegal
0004
C109 E129 C201 0000
1 0001
1 0001 0009
0000

//--- tb.f
hw/wiscPkg.sv
hw/control.sv
hw/aluUnit.sv
hw/regFile.sv
hw/fetchUnit.sv
hw/dataMem.sv
hw/wiscCore.sv
bench/wiscCoreTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Builds the WISC core testbench with Verilator, runs it and looks for the pass banner
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module wiscCoreTb -f tb.f &&
./obj_dir/VwiscCoreTb | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- bench/wiscCoreTb.sv
// Testbench that runs the programs of the cases file on the WISC core and checks its trace events
`timescale 1ns/100ps

module wiscCoreTb;
    import wiscPkg::*;

    localparam int          clkPeriod   = 20;
    localparam int          driveDelay  = 2;        // Inputs change this long after the edge
    localparam int          resetCycles = 3;
    localparam int          haltTimeout = 500;      // Cycles allowed per program
    localparam int          quietCycles = 5;        // Cycles watched after the halt
    localparam int          caseWords   = 1024;
    localparam logic [15:0] evReg       = 16'h1;    // Register write event
    localparam logic [15:0] evMem       = 16'h2;    // Data memory write event

    logic                 clk;
    logic                 rstN;
    logic                 run;
    logic                 loadEn;
    logic [imemAddrW-1:0] loadAddr;
    logic [wordW-1:0]     loadData;
    logic                 wbValid;
    logic [regAddrW-1:0]  wbReg;
    logic [wordW-1:0]     wbData;
    logic                 memWrValid;
    logic [wordW-1:0]     memWrAddr;
    logic [wordW-1:0]     memWrData;
    logic                 halted;
    logic                 illegal;

    logic [15:0] caseMem [caseWords];               // Whole cases file
    logic [15:0] obsKind [$];                       // Events seen in the current program
    logic [15:0] obsAddr [$];
    logic [15:0] obsData [$];
    int          ptr;                               // Start of the next case in caseMem
    int          caseNum;
    int          checks;
    int          errors;
    int          timeouts;
    bit          timedOut;

    wiscCore dut (
        .clk, .rstN, .run, .loadEn, .loadAddr, .loadData, .wbValid, .wbReg, .wbData,
        .memWrValid, .memWrAddr, .memWrData, .halted, .illegal
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic waitDriveSlot();
        @(posedge clk);
        #driveDelay;                                // Clear of the edge
    endtask

    task automatic resetCore();
        waitDriveSlot();
        rstN   = 1'b0;
        run    = 1'b0;
        loadEn = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        checks++;
        if (halted || wbValid || memWrValid) begin   // Trace outputs idle out of reset
            $display("FAIL %0t: case %0d outputs not idle after reset", $time, caseNum);
            errors++;
        end
        rstN = 1'b1;
    endtask

    task automatic loadProgram(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            loadEn   = 1'b1;
            loadAddr = imemAddrW'(i);
            loadData = caseMem[first + i];
            waitDriveSlot();                        // Word lands at this edge
        end
        loadEn = 1'b0;
    endtask

    task automatic recordEvents();
        if (wbValid) begin                          // Register write first in a cycle
            obsKind.push_back(evReg);
            obsAddr.push_back(16'(wbReg));
            obsData.push_back(wbData);
        end
        if (memWrValid) begin
            obsKind.push_back(evMem);
            obsAddr.push_back(memWrAddr);
            obsData.push_back(memWrData);
        end
    endtask

    task automatic runUntilHalt(output bit done);
        int cycles;
        cycles = 0;
        run    = 1'b1;                              // PC starts at zero
        while (!halted && cycles < haltTimeout) begin
            @(negedge clk);                         // Events settled mid cycle
            recordEvents();
            cycles++;
        end
        done = halted;
    endtask

    task automatic checkQuiet();
        repeat (quietCycles) begin
            @(negedge clk);
            checks++;
            if (wbValid || memWrValid) begin
                $display("FAIL %0t: case %0d write event after halt", $time, caseNum);
                errors++;
            end
            checks++;
            if (!halted) begin
                $display("FAIL %0t: case %0d halted dropped before reset", $time, caseNum);
                errors++;
            end
        end
    endtask

    task automatic compareEvents(input int evStart, input int evCount);
        int n;
        int at;
        n = (obsKind.size() < evCount) ? obsKind.size() : evCount;
        checks++;
        if (obsKind.size() != evCount) begin
            $display("FAIL %0t: case %0d saw %0d events, expected %0d",
                     $time, caseNum, obsKind.size(), evCount);
            errors++;
        end
        for (int i = 0; i < n; i++) begin
            at = evStart + 3 * i;                   // Kind, register or address, data
            checks++;
            if (obsKind[i] !== caseMem[at] || obsAddr[i] !== caseMem[at + 1] ||
                obsData[i] !== caseMem[at + 2]) begin
                $display("FAIL %0t: case %0d event %0d expected %0h %h %h, got %0h %h %h",
                         $time, caseNum, i, caseMem[at], caseMem[at + 1], caseMem[at + 2],
                         obsKind[i], obsAddr[i], obsData[i]);
                errors++;
            end
        end
    endtask

    task automatic runCase();
        int   progLen;
        int   progStart;
        int   evCount;
        int   evStart;
        logic expIllegal;
        bit   done;
        progLen    = int'(caseMem[ptr]);
        progStart  = ptr + 1;
        expIllegal = caseMem[progStart + progLen][0];
        evCount    = int'(caseMem[progStart + progLen + 1]);
        evStart    = progStart + progLen + 2;
        ptr        = evStart + 3 * evCount;         // Next case header
        caseNum++;
        obsKind.delete();
        obsAddr.delete();
        obsData.delete();
        resetCore();
        loadProgram(progStart, progLen);
        runUntilHalt(done);
        if (!done) begin
            $display("Case %0d timed out: the core did not halt within %0d cycles",
                     caseNum, haltTimeout);
            timeouts++;
            timedOut = 1'b1;
        end else begin
            checkQuiet();
            compareEvents(evStart, evCount);
            checks++;
            if (illegal !== expIllegal) begin
                $display("FAIL %0t: case %0d illegal is %b, expected %b",
                         $time, caseNum, illegal, expIllegal);
                errors++;
            end
        end
    endtask

    initial begin
        rstN     = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        ptr      = 0;
        caseNum  = 0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        timedOut = 1'b0;
        $readmemh("bench/coreCases.txt", caseMem);
        if ($isunknown(caseMem[0]) || caseMem[0] == 16'h0) begin
            $display("No programs could be read from bench/coreCases.txt");
            errors++;
        end
        while (!timedOut && ptr < caseWords && caseMem[ptr] != 16'h0) begin
            runCase();                              // Zero length ends the list
        end
        $display("Cases %0d, checks %0d, errors %0d, timeouts %0d",
                 caseNum, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- hw/wiscCore.sv
// Single cycle WISC core wiring fetch, decode, registers, ALU and data memory with trace ports
`timescale 1ns/100ps

module wiscCore (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          run,
    input  logic                          loadEn,
    input  logic [wiscPkg::imemAddrW-1:0] loadAddr,
    input  logic [wiscPkg::wordW-1:0]     loadData,
    output logic                          wbValid,
    output logic [wiscPkg::regAddrW-1:0]  wbReg,
    output logic [wiscPkg::wordW-1:0]     wbData,
    output logic                          memWrValid,
    output logic [wiscPkg::wordW-1:0]     memWrAddr,
    output logic [wiscPkg::wordW-1:0]     memWrData,
    output logic                          halted,
    output logic                          illegal
);
    import wiscPkg::*;

    instrWord_u       instr;
    logic [wordW-1:0] pcPlus2;
    logic             regWrite;
    logic [1:0]       destSel;
    logic [2:0]       immSel;
    logic [4:0]       aluOp;
    logic             aluSrcImm;
    logic             memEn;
    logic             memWr;
    logic [1:0]       wbSel;
    logic             branchTaken;
    logic             regJmp;
    logic             decHalt;
    logic             decIllegal;
    logic [wordW-1:0] rdDataA;
    logic [wordW-1:0] rdDataB;                  // Rt, or Rd as store data in I-format
    logic [wordW-1:0] immExt;
    logic [wordW-1:0] aluResult;
    logic [wordW-1:0] memRdData;
    logic             zeroFlag;
    logic             signFlag;
    logic             retire;
    logic             stall;

    assign retire = rstN && run && !halted;     // One instruction per running cycle
    assign stall  = halted || decHalt || decIllegal;

    fetchUnit uFetch (
        .clk, .rstN, .run, .stall, .loadEn, .loadAddr, .loadData, .branchTaken, .regJmp,
        .jumpImm(immExt), .regBase(rdDataA), .instr, .pcPlus2
    );

    control uControl (
        .instr, .zeroFlag, .signFlag, .regWrite, .destSel, .immSel, .aluOp, .aluSrcImm,
        .memEn, .memWr, .wbSel, .branchTaken, .regJmp, .halt(decHalt), .illegal(decIllegal)
    );

    regFile uRegs (
        .clk, .rstN, .rdAddrA(instr.rFmt.rs), .rdAddrB(instr.rFmt.rt),
        .wrEn(wbValid), .wrAddr(wbReg), .wrData(wbData), .rdDataA, .rdDataB
    );

    aluUnit uAlu (
        .opA(rdDataA), .opB(aluSrcImm ? immExt : rdDataB), .aluOp, .func(instr.rFmt.func),
        .result(aluResult), .zeroFlag, .signFlag
    );

    dataMem uDmem (
        .clk, .en(memEn && retire), .wr(memWr), .addr(aluResult), .wrData(rdDataB),
        .rdData(memRdData)
    );

    always_comb begin
        unique case (immSel)
            immZ5:   immExt = {11'b0, instr.i1Fmt.imm};
            immS5:   immExt = {{11{instr.i1Fmt.imm[4]}}, instr.i1Fmt.imm};
            immZ8:   immExt = {8'b0, instr.i2Fmt.imm};
            immS8:   immExt = {{8{instr.i2Fmt.imm[7]}}, instr.i2Fmt.imm};
            immS11:  immExt = {{5{instr.jFmt.disp[10]}}, instr.jFmt.disp};
            default: immExt = '0;
        endcase
    end

    always_comb begin
        unique case (destSel)
            destRs:  wbReg = instr.rFmt.rs;     // STU base update, LBI and SLBI
            destRdR: wbReg = instr.rFmt.rd;
            destR7:  wbReg = 3'd7;              // Link register
            default: wbReg = instr.i1Fmt.rd;
        endcase
        unique case (wbSel)
            wbMem:   wbData = memRdData;
            wbLink:  wbData = pcPlus2;
            default: wbData = aluResult;
        endcase
    end

    assign wbValid    = regWrite && retire;
    assign memWrValid = memEn && memWr && retire;
    assign memWrAddr  = aluResult;
    assign memWrData  = rdDataB;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else if (retire) begin
            if (decHalt || decIllegal) begin
                halted <= 1'b1;                 // Sticky until reset
            end
            if (decIllegal) begin
                illegal <= 1'b1;
            end
        end
    end

    // Once halted the fetch side must hold the same instruction word
    haltFreeze: assert property (@(posedge clk) disable iff (!rstN)
        halted && run |=> $stable(instr))
        else $error("instruction changed after halt");

endmodule

//--- hw/dataMem.sv
// Word addressed data memory with combinational read and clocked write
`timescale 1ns/100ps

module dataMem (
    input  logic                      clk,
    input  logic                      en,
    input  logic                      wr,
    input  logic [wiscPkg::wordW-1:0] addr,     // Byte address
    input  logic [wiscPkg::wordW-1:0] wrData,
    output logic [wiscPkg::wordW-1:0] rdData
);
    import wiscPkg::*;

    logic [wordW-1:0] mem [dmemDepth];

    assign rdData = en ? mem[addr[dmemAddrW:1]] : '0; // Idle reads return zero

    always_ff @(posedge clk) begin
        if (en && wr) begin
            mem[addr[dmemAddrW:1]] <= wrData;
        end
    end

endmodule

//--- hw/fetchUnit.sv
// Fetch stage with PC register, loadable instruction memory and next PC selection
`timescale 1ns/100ps

module fetchUnit (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          run,
    input  logic                          stall,       // Halt decoded or already halted
    input  logic                          loadEn,
    input  logic [wiscPkg::imemAddrW-1:0] loadAddr,    // Word address
    input  logic [wiscPkg::wordW-1:0]     loadData,
    input  logic                          branchTaken,
    input  logic                          regJmp,
    input  logic [wiscPkg::wordW-1:0]     jumpImm,     // Extended branch or jump offset
    input  logic [wiscPkg::wordW-1:0]     regBase,     // Rs for JR and JALR
    output wiscPkg::instrWord_u           instr,
    output logic [wiscPkg::wordW-1:0]     pcPlus2
);
    import wiscPkg::*;

    logic [wordW-1:0] pc;
    logic [wordW-1:0] nextPc;
    logic [wordW-1:0] imem [imemDepth];

    assign pcPlus2 = pc + wordW'(2);
    assign instr   = imem[pc[imemAddrW:1]];     // Byte PC to word index

    always_comb begin
        if (branchTaken) begin
            nextPc = pcPlus2 + jumpImm;         // Branches plus J and JAL
        end else if (regJmp) begin
            nextPc = regBase + jumpImm;
        end else begin
            nextPc = pcPlus2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || !run) begin
            pc <= '0;                           // Idle core waits at address zero
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (loadEn && !run) begin
            imem[loadAddr] <= loadData;         // Program load only while stopped
        end
    end

    // Odd targets from JR or JALR would split instruction words
    pcEven: assert property (@(posedge clk) disable iff (!rstN) run |-> !pc[0])
        else $error("PC became odd");

endmodule

//--- hw/regFile.sv
// Eight by sixteen register file with two combinational reads and one clocked write
`timescale 1ns/100ps

module regFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [wiscPkg::regAddrW-1:0] rdAddrA,
    input  logic [wiscPkg::regAddrW-1:0] rdAddrB,
    input  logic                         wrEn,
    input  logic [wiscPkg::regAddrW-1:0] wrAddr,
    input  logic [wiscPkg::wordW-1:0]    wrData,
    output logic [wiscPkg::wordW-1:0]    rdDataA,
    output logic [wiscPkg::wordW-1:0]    rdDataB
);
    import wiscPkg::*;

    logic [wordW-1:0] regs [1<<regAddrW];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < (1 << regAddrW); i++) begin
                regs[i] <= '0;                  // Programs start from all zero registers
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];             // No bypass, a write shows next cycle
    assign rdDataB = regs[rdAddrB];

endmodule

//--- hw/aluUnit.sv
// Sixteen bit ALU for arithmetic, logic, shift, rotate, compare and byte loads with Rs flags
`timescale 1ns/100ps

module aluUnit (
    input  logic [wiscPkg::wordW-1:0] opA,      // Always Rs
    input  logic [wiscPkg::wordW-1:0] opB,      // Rt or the extended immediate
    input  logic [4:0]                aluOp,
    input  logic [1:0]                func,
    output logic [wiscPkg::wordW-1:0] result,
    output logic                      zeroFlag,
    output logic                      signFlag
);
    import wiscPkg::*;

    logic [4:0]         effOp;
    logic [3:0]         shAmt;
    logic [2*wordW-1:0] rolWide;
    logic [2*wordW-1:0] rorWide;
    logic [wordW:0]     sum;
    logic [wordW-1:0]   revA;
    logic               opKnown;

    // R-format groups fold onto the matching I-format codes by func
    always_comb begin
        unique case (aluOp)
            aluAluR: effOp = {aluAdd[4:2], func};
            aluShfR: effOp = {aluRol[4:2], func};
            default: effOp = aluOp;
        endcase
    end

    assign shAmt   = opB[3:0];                  // Only the low nibble counts
    assign rolWide = {opA, opA} << shAmt;
    assign rorWide = {opA, opA} >> shAmt;
    assign sum     = {1'b0, opA} + {1'b0, opB}; // Carry kept for SCO

    always_comb begin
        for (int i = 0; i < wordW; i++) begin
            revA[i] = opA[wordW-1-i];           // BTR bit reversal
        end
    end

    always_comb begin
        opKnown = 1'b1;
        unique case (effOp)
            aluAdd:  result = sum[wordW-1:0];
            aluSub:  result = opB - opA;
            aluXor:  result = opA ^ opB;
            aluAndn: result = opA & ~opB;
            aluRol:  result = rolWide[2*wordW-1:wordW];
            aluSll:  result = opA << shAmt;
            aluRor:  result = rorWide[wordW-1:0];
            aluSrl:  result = opA >> shAmt;
            aluSeq:  result = wordW'(opA == opB);
            aluSlt:  result = wordW'($signed(opA) < $signed(opB));
            aluSle:  result = wordW'($signed(opA) <= $signed(opB));
            aluSco:  result = wordW'(sum[wordW]);
            aluBtr:  result = revA;
            aluLbi:  result = opB;
            aluSlbi: result = (opA << 8) | opB;
            default: begin
                result  = '0;
                opKnown = 1'b0;
            end
        endcase
        assert (opKnown) else $error("ALU given an operation it does not implement");
    end

    assign zeroFlag = (opA == '0);              // Branch conditions test Rs
    assign signFlag = opA[wordW-1];

endmodule

//--- hw/control.sv
// Instruction decoder producing every datapath control and the branch decision
`timescale 1ns/100ps

module control (
    input  wiscPkg::instrWord_u instr,
    input  logic                zeroFlag,       // Rs is zero
    input  logic                signFlag,       // Rs is negative
    output logic                regWrite,
    output logic [1:0]          destSel,
    output logic [2:0]          immSel,
    output logic [4:0]          aluOp,
    output logic                aluSrcImm,      // ALU B from immediate
    output logic                memEn,
    output logic                memWr,
    output logic [1:0]          wbSel,
    output logic                branchTaken,    // PC+2+imm next
    output logic                regJmp,         // Rs+imm next
    output logic                halt,
    output logic                illegal
);
    import wiscPkg::*;

    logic [4:0] opcode;

    assign opcode = instr.rFmt.opcode;

    always_comb begin
        regWrite    = 1'b0;                     // Safe defaults keep this latch free
        destSel     = destRdI;
        immSel      = immS5;
        aluOp       = aluAdd;
        aluSrcImm   = 1'b1;
        memEn       = 1'b0;
        memWr       = 1'b0;
        wbSel       = wbAlu;
        branchTaken = 1'b0;
        regJmp      = 1'b0;
        halt        = 1'b0;
        illegal     = 1'b0;
        unique case (opcode)
            opHalt: halt = 1'b1;
            opNop, opSiic, opRti: begin
            end
            opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
                regWrite = 1'b1;
                aluOp    = opcode;
                immSel   = opcode[1] ? immZ5 : immS5; // XORI and ANDNI zero extend
            end
            opSt: begin
                memEn = 1'b1;                   // Address is Rs+imm from the ALU
                memWr = 1'b1;
            end
            opLd: begin
                regWrite = 1'b1;
                memEn    = 1'b1;
                wbSel    = wbMem;
            end
            opStu: begin
                regWrite = 1'b1;                // Rs takes the effective address
                memEn    = 1'b1;
                memWr    = 1'b1;
                destSel  = destRs;
            end
            opAluR, opShfR: begin
                regWrite  = 1'b1;
                destSel   = destRdR;
                aluSrcImm = 1'b0;
                aluOp     = opcode;             // ALU picks the exact op from func
            end
            opBtr, opSeq, opSlt, opSle, opSco: begin
                // These forms reserve func, anything but 00 traps
                illegal   = (instr.rFmt.func != 2'b00);
                regWrite  = !illegal;
                destSel   = destRdR;
                aluSrcImm = 1'b0;
                aluOp     = opcode;
            end
            opBeqz, opBnez, opBltz, opBgez: begin
                immSel = immS8;
                unique case (opcode)
                    opBeqz:  branchTaken = zeroFlag;
                    opBnez:  branchTaken = !zeroFlag;
                    opBltz:  branchTaken = signFlag;
                    default: branchTaken = !signFlag; // BGEZ
                endcase
            end
            opLbi: begin
                regWrite = 1'b1;
                destSel  = destRs;
                immSel   = immS8;
                aluOp    = aluLbi;
            end
            opSlbi: begin
                regWrite = 1'b1;
                destSel  = destRs;
                immSel   = immZ8;               // Low byte shifted in unsigned
                aluOp    = aluSlbi;
            end
            opJ: begin
                branchTaken = 1'b1;
                immSel      = immS11;
            end
            opJal: begin
                branchTaken = 1'b1;
                immSel      = immS11;
                regWrite    = 1'b1;             // Link into R7 with no memory access
                destSel     = destR7;
                wbSel       = wbLink;
            end
            opJr: begin
                regJmp = 1'b1;
                immSel = immS8;
            end
            opJalr: begin
                regJmp   = 1'b1;
                immSel   = immS8;
                regWrite = 1'b1;
                destSel  = destR7;
                wbSel    = wbLink;
            end
            default: illegal = 1'b1;            // Only an unknown opcode lands here
        endcase
    end

endmodule

//--- hw/wiscPkg.sv
// WISC core package with widths, opcode and control encodings and the instruction word views
package wiscPkg;

    localparam int wordW     = 16;                  // Data and instruction width
    localparam int regAddrW  = 3;                   // Eight registers
    localparam int imemDepth = 256;                 // Instruction memory words
    localparam int dmemDepth = 256;                 // Data memory words
    localparam int imemAddrW = $clog2(imemDepth);   // Word index into instruction memory
    localparam int dmemAddrW = $clog2(dmemDepth);   // Word index into data memory

    // Opcodes in instr[15:11]
    localparam logic [4:0] opHalt  = 5'b00000;
    localparam logic [4:0] opNop   = 5'b00001;
    localparam logic [4:0] opSiic  = 5'b00010;      // Runs as nop here
    localparam logic [4:0] opRti   = 5'b00011;      // Runs as nop here
    localparam logic [4:0] opJ     = 5'b00100;
    localparam logic [4:0] opJr    = 5'b00101;
    localparam logic [4:0] opJal   = 5'b00110;
    localparam logic [4:0] opJalr  = 5'b00111;
    localparam logic [4:0] opAddi  = 5'b01000;
    localparam logic [4:0] opSubi  = 5'b01001;
    localparam logic [4:0] opXori  = 5'b01010;
    localparam logic [4:0] opAndni = 5'b01011;
    localparam logic [4:0] opBeqz  = 5'b01100;
    localparam logic [4:0] opBnez  = 5'b01101;
    localparam logic [4:0] opBltz  = 5'b01110;
    localparam logic [4:0] opBgez  = 5'b01111;
    localparam logic [4:0] opSt    = 5'b10000;
    localparam logic [4:0] opLd    = 5'b10001;
    localparam logic [4:0] opSlbi  = 5'b10010;
    localparam logic [4:0] opStu   = 5'b10011;
    localparam logic [4:0] opRoli  = 5'b10100;
    localparam logic [4:0] opSlli  = 5'b10101;
    localparam logic [4:0] opRori  = 5'b10110;
    localparam logic [4:0] opSrli  = 5'b10111;
    localparam logic [4:0] opLbi   = 5'b11000;
    localparam logic [4:0] opBtr   = 5'b11001;
    localparam logic [4:0] opShfR  = 5'b11010;      // ROL SLL ROR SRL by func
    localparam logic [4:0] opAluR  = 5'b11011;      // ADD SUB XOR ANDN by func
    localparam logic [4:0] opSeq   = 5'b11100;
    localparam logic [4:0] opSlt   = 5'b11101;
    localparam logic [4:0] opSle   = 5'b11110;
    localparam logic [4:0] opSco   = 5'b11111;

    // ALU operations share the opcode values
    localparam logic [4:0] aluAdd  = opAddi;
    localparam logic [4:0] aluSub  = opSubi;        // B minus A
    localparam logic [4:0] aluXor  = opXori;
    localparam logic [4:0] aluAndn = opAndni;
    localparam logic [4:0] aluRol  = opRoli;
    localparam logic [4:0] aluSll  = opSlli;
    localparam logic [4:0] aluRor  = opRori;
    localparam logic [4:0] aluSrl  = opSrli;
    localparam logic [4:0] aluSlbi = opSlbi;
    localparam logic [4:0] aluLbi  = opLbi;
    localparam logic [4:0] aluBtr  = opBtr;
    localparam logic [4:0] aluShfR = opShfR;
    localparam logic [4:0] aluAluR = opAluR;
    localparam logic [4:0] aluSeq  = opSeq;
    localparam logic [4:0] aluSlt  = opSlt;
    localparam logic [4:0] aluSle  = opSle;
    localparam logic [4:0] aluSco  = opSco;

    // Immediate select is sign bit then size
    localparam logic [2:0] immZ5  = 3'b000;
    localparam logic [2:0] immZ8  = 3'b001;
    localparam logic [2:0] immS5  = 3'b100;
    localparam logic [2:0] immS8  = 3'b101;
    localparam logic [2:0] immS11 = 3'b110;

    localparam logic [1:0] destRs  = 2'b00;
    localparam logic [1:0] destRdR = 2'b01;
    localparam logic [1:0] destR7  = 2'b10;
    localparam logic [1:0] destRdI = 2'b11;

    localparam logic [1:0] wbAlu  = 2'b00;
    localparam logic [1:0] wbMem  = 2'b01;
    localparam logic [1:0] wbLink = 2'b10;          // PC+2 for JAL and JALR

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } rFmt_s;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm;
    } i1Fmt_s;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [7:0] imm;
    } i2Fmt_s;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [10:0] disp;
    } jFmt_s;

    typedef union packed {
        rFmt_s  rFmt;
        i1Fmt_s i1Fmt;
        i2Fmt_s i2Fmt;
        jFmt_s  jFmt;
    } instrWord_u;

endpackage
